// File: rtl/mem_cfg_pkg.sv
package mem_cfg_pkg;

	// ======================================================================
	// Warp and scoreboard geometry
	// ======================================================================

	localparam int NUM_LANES = 8;
	localparam int LANE_W    = 32;
	localparam int WARP_W    = 3;
	localparam int SCB_W     = 2;
	localparam int REG_W     = 5;
	localparam int OFFSET_W  = 8;

	// ======================================================================
	// Memory geometry
	// ======================================================================

	// Shared memory, 8 banks of 32 rows.
	localparam int BANK_W    = 3;
	localparam int SH_ROW_W  = 5;
	localparam int NUM_BANKS = 1 << BANK_W;
	localparam int SH_ROWS   = 1 << SH_ROW_W;

	// Global memory, 64 lines of 8 words.
	localparam int WORD_W     = 3;
	localparam int LINE_W     = 6;
	localparam int LINE_WORDS = 1 << WORD_W;
	localparam int NUM_LINES  = 1 << LINE_W;

	// Fill port addresses whole lines.
	localparam int FILL_ADDR_W = LINE_W;

endpackage

// File: rtl/mem_types_pkg.sv
package mem_types_pkg;

	import mem_cfg_pkg::*;

	typedef logic [LANE_W-1:0] lane_word_t;

	// One value per lane.
	typedef lane_word_t [NUM_LANES-1:0] warp_data_t;

	typedef logic [NUM_LANES-1:0] lane_mask_t;

	// Shared view, bank in the low bits.
	typedef struct packed {
		logic [LANE_W-SH_ROW_W-BANK_W-1:0] hi;
		logic [SH_ROW_W-1:0]               row;
		logic [BANK_W-1:0]                 bank;
	} sh_view_t;

	// Global view, word within the line in the low bits.
	typedef struct packed {
		logic [LANE_W-LINE_W-WORD_W-1:0] hi;
		logic [LINE_W-1:0]               line;
		logic [WORD_W-1:0]               word;
	} gl_view_t;

	typedef union packed {
		sh_view_t sh;
		gl_view_t gl;
	} lane_addr_u;

	typedef lane_addr_u [NUM_LANES-1:0] lane_addr_arr_t;

endpackage

// File: rtl/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             instr_valid_i,
	input  logic                             mem_read_i,
	input  logic                             mem_write_i,
	input  logic                             shared_i,
	input  mem_types_pkg::lane_mask_t        pam_i,
	input  logic [mem_cfg_pkg::WARP_W-1:0]   warp_id_i,
	input  logic [mem_cfg_pkg::SCB_W-1:0]    scb_id_i,
	input  logic [mem_cfg_pkg::REG_W-1:0]    reg_addr_i,
	input  logic                             conflict_i,
	output logic                             shared_o,
	output mem_types_pkg::lane_mask_t        mask_o,
	output logic                             mem_rd_o,
	output logic                             mem_wr_o,
	output mem_types_pkg::lane_mask_t        acc_mask_o,
	output logic                             acc_shared_o,
	output logic                             wb_load_o,
	output logic                             wb_valid_o,
	output logic [mem_cfg_pkg::WARP_W-1:0]   wb_warp_o,
	output logic [mem_cfg_pkg::SCB_W-1:0]    wb_scb_o,
	output logic [mem_cfg_pkg::REG_W-1:0]    wb_reg_o,
	output mem_types_pkg::lane_mask_t        wb_mask_o,
	output logic                             neg_fb_valid_o,
	output logic [mem_cfg_pkg::WARP_W-1:0]   neg_fb_warp_o,
	output logic [mem_cfg_pkg::SCB_W-1:0]    neg_fb_scb_o
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	logic              s1_valid, s1_rd, s1_wr, s1_shared;
	lane_mask_t        s1_mask;
	logic [WARP_W-1:0] s1_warp;
	logic [SCB_W-1:0]  s1_scb;
	logic [REG_W-1:0]  s1_reg;

	logic              s2_valid, s2_rd, s2_wr, s2_shared;
	lane_mask_t        s2_mask;
	logic [WARP_W-1:0] s2_warp;
	logic [SCB_W-1:0]  s2_scb;
	logic [REG_W-1:0]  s2_reg;

	logic [WARP_W-1:0] s3_warp;
	logic [SCB_W-1:0]  s3_scb;
	logic [REG_W-1:0]  s3_reg;

	logic              s2_access, s2_accept, s2_reject;

	// ======================================================================
	// Stage valids and enables
	// ======================================================================

	assign s2_access = s2_valid & (s2_rd | s2_wr);
	assign s2_reject = s2_access & conflict_i;
	assign s2_accept = s2_access & ~conflict_i;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			s1_valid       <= 1'b0;
			s2_valid       <= 1'b0;
			neg_fb_valid_o <= 1'b0;
			mem_rd_o       <= 1'b0;
			mem_wr_o       <= 1'b0;
			wb_valid_o     <= 1'b0;
			wb_load_o      <= 1'b0;
		end
		else
		begin
			s1_valid       <= instr_valid_i;
			s2_valid       <= s1_valid;
			neg_fb_valid_o <= s2_reject;
			// A load that also has write set is handled as a load.
			mem_rd_o       <= s2_accept & s2_rd;
			mem_wr_o       <= s2_accept & s2_wr & ~s2_rd;
			wb_valid_o     <= mem_rd_o | mem_wr_o;
			wb_load_o      <= mem_rd_o;
		end
	end

	// ======================================================================
	// Tags
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (instr_valid_i)
		begin
			s1_rd     <= mem_read_i;
			s1_wr     <= mem_write_i;
			s1_shared <= shared_i;
			s1_mask   <= pam_i;
			s1_warp   <= warp_id_i;
			s1_scb    <= scb_id_i;
			s1_reg    <= reg_addr_i;
		end
		s2_rd        <= s1_rd;
		s2_wr        <= s1_wr;
		s2_shared    <= s1_shared;
		s2_mask      <= s1_mask;
		s2_warp      <= s1_warp;
		s2_scb       <= s1_scb;
		s2_reg       <= s1_reg;
		acc_shared_o <= s2_shared;
		acc_mask_o   <= s2_mask;
		s3_warp      <= s2_warp;
		s3_scb       <= s2_scb;
		s3_reg       <= s2_reg;
		wb_warp_o    <= s3_warp;
		wb_scb_o     <= s3_scb;
		wb_reg_o     <= s3_reg;
		wb_mask_o    <= acc_mask_o;
	end

	assign shared_o      = s1_shared;
	assign mask_o        = s1_mask;
	assign neg_fb_warp_o = s3_warp;
	assign neg_fb_scb_o  = s3_scb;

endmodule

// File: rtl/mem_addr_gen.sv
`timescale 1ns/1ps

module mem_addr_gen (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             instr_valid_i,
	input  mem_types_pkg::warp_data_t        rs_data_i,
	input  mem_types_pkg::warp_data_t        rt_data_i,
	input  logic [mem_cfg_pkg::OFFSET_W-1:0] offset_i,
	input  logic                             shared_i,
	input  mem_types_pkg::lane_mask_t        mask_i,
	output mem_types_pkg::lane_addr_arr_t    addr_o,
	output mem_types_pkg::warp_data_t        wdata_o,
	output logic                             conflict_o
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	warp_data_t      rs_q, rt_q;
	logic [OFFSET_W-1:0] off_q;

	lane_addr_arr_t  eff;
	logic            bank_clash, line_split;

	always_ff @(posedge clk)
	begin
		if (instr_valid_i)
		begin
			rs_q  <= rs_data_i;
			rt_q  <= rt_data_i;
			off_q <= offset_i;
		end
	end

	// Effective address, offset is unsigned.
	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
			eff[l] = rs_q[l] + LANE_W'(off_q);
	end

	// Pairwise check over active lanes only.
	always_comb
	begin
		bank_clash = 1'b0;
		line_split = 1'b0;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			for (int j = i + 1; j < NUM_LANES; j++)
			begin
				if (mask_i[i] && mask_i[j])
				begin
					if (eff[i].sh.bank == eff[j].sh.bank && eff[i].sh.row != eff[j].sh.row)
						bank_clash = 1'b1;
					if (eff[i].gl.line != eff[j].gl.line)
						line_split = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			conflict_o <= 1'b0;
		else
			conflict_o <= shared_i ? bank_clash : line_split;
	end

	always_ff @(posedge clk)
	begin
		addr_o  <= eff;
		wdata_o <= rt_q;
	end

endmodule

// File: rtl/mem_bank_array.sv
`timescale 1ns/1ps

module mem_bank_array (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                mem_rd_i,
	input  logic                                mem_wr_i,
	input  logic                                shared_i,
	input  mem_types_pkg::lane_mask_t           mask_i,
	input  mem_types_pkg::lane_addr_arr_t       addr_i,
	input  mem_types_pkg::warp_data_t           wdata_i,
	input  logic                                fill_we_i,
	input  logic [mem_cfg_pkg::FILL_ADDR_W-1:0] fill_line_i,
	input  mem_types_pkg::warp_data_t           fill_data_i,
	output mem_types_pkg::warp_data_t           rdata_o
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	// ======================================================================
	// Storage
	// ======================================================================

	lane_word_t sh_mem [NUM_BANKS][SH_ROWS];
	lane_word_t gl_mem [NUM_LINES][LINE_WORDS];

	// Address and data held for the access cycle.
	lane_addr_arr_t addr_q;
	warp_data_t     wdata_q;

	warp_data_t     rd_sel;

	always_ff @(posedge clk)
	begin
		addr_q  <= addr_i;
		wdata_q <= wdata_i;
	end

	// ======================================================================
	// Writes
	// ======================================================================

	// Fill goes first so a store to the same word overrides it.
	// Lanes in ascending order, the highest active lane wins.
	always_ff @(posedge clk)
	begin
		if (fill_we_i)
		begin
			for (int w = 0; w < LINE_WORDS; w++)
				gl_mem[fill_line_i][w] <= fill_data_i[w];
		end
		if (mem_wr_i)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (mask_i[l])
				begin
					if (shared_i)
						sh_mem[addr_q[l].sh.bank][addr_q[l].sh.row] <= wdata_q[l];
					else
						gl_mem[addr_q[l].gl.line][addr_q[l].gl.word] <= wdata_q[l];
				end
			end
		end
	end

	// ======================================================================
	// Reads
	// ======================================================================

	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
		begin
			if (!mask_i[l])
				rd_sel[l] = '0;
			else if (shared_i)
				rd_sel[l] = sh_mem[addr_q[l].sh.bank][addr_q[l].sh.row];
			else
				rd_sel[l] = gl_mem[addr_q[l].gl.line][addr_q[l].gl.word];
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			rdata_o <= '0;
		else if (mem_rd_i)
			rdata_o <= rd_sel;
	end

endmodule

// File: rtl/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           wb_valid_i,
	input  logic                           wb_load_i,
	input  logic [mem_cfg_pkg::WARP_W-1:0] wb_warp_i,
	input  logic [mem_cfg_pkg::SCB_W-1:0]  wb_scb_i,
	input  logic [mem_cfg_pkg::REG_W-1:0]  wb_reg_i,
	input  mem_types_pkg::lane_mask_t      wb_mask_i,
	input  mem_types_pkg::warp_data_t      rdata_i,
	output logic                           pos_fb_valid_o,
	output logic [mem_cfg_pkg::WARP_W-1:0] pos_fb_warp_o,
	output logic [mem_cfg_pkg::SCB_W-1:0]  pos_fb_scb_o,
	output mem_types_pkg::lane_mask_t      pos_fb_mask_o,
	output logic                           cdb_we_o,
	output logic [mem_cfg_pkg::REG_W-1:0]  cdb_reg_o,
	output mem_types_pkg::lane_mask_t      cdb_mask_o,
	output mem_types_pkg::warp_data_t      cdb_data_o
);

	import mem_types_pkg::*;

	lane_mask_t mask_q;

	// One-cycle strobes, stores give feedback only.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pos_fb_valid_o <= 1'b0;
			cdb_we_o       <= 1'b0;
		end
		else
		begin
			pos_fb_valid_o <= wb_valid_i;
			cdb_we_o       <= wb_valid_i & wb_load_i;
		end
	end

	always_ff @(posedge clk)
	begin
		pos_fb_warp_o <= wb_warp_i;
		pos_fb_scb_o  <= wb_scb_i;
		cdb_reg_o     <= wb_reg_i;
		mask_q        <= wb_mask_i;
		cdb_data_o    <= rdata_i;
	end

	// Feedback and CDB carry the same lane mask.
	assign pos_fb_mask_o = mask_q;
	assign cdb_mask_o    = mask_q;

endmodule

// File: rtl/mem_unit.sv
`timescale 1ns/1ps

module mem_unit (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                instr_valid_i,
	input  logic                                mem_read_i,
	input  logic                                mem_write_i,
	input  logic                                shared_i,
	input  mem_types_pkg::lane_mask_t           pam_i,
	input  logic [mem_cfg_pkg::WARP_W-1:0]      warp_id_i,
	input  logic [mem_cfg_pkg::SCB_W-1:0]       scb_id_i,
	input  logic [mem_cfg_pkg::REG_W-1:0]       reg_addr_i,
	input  mem_types_pkg::warp_data_t           rs_data_i,
	input  mem_types_pkg::warp_data_t           rt_data_i,
	input  logic [mem_cfg_pkg::OFFSET_W-1:0]    offset_i,
	input  logic                                fill_we_i,
	input  logic [mem_cfg_pkg::FILL_ADDR_W-1:0] fill_line_i,
	input  mem_types_pkg::warp_data_t           fill_data_i,
	output logic                                neg_fb_valid_o,
	output logic [mem_cfg_pkg::WARP_W-1:0]      neg_fb_warp_o,
	output logic [mem_cfg_pkg::SCB_W-1:0]       neg_fb_scb_o,
	output logic                                pos_fb_valid_o,
	output logic [mem_cfg_pkg::WARP_W-1:0]      pos_fb_warp_o,
	output logic [mem_cfg_pkg::SCB_W-1:0]       pos_fb_scb_o,
	output mem_types_pkg::lane_mask_t           pos_fb_mask_o,
	output logic                                cdb_we_o,
	output logic [mem_cfg_pkg::REG_W-1:0]       cdb_reg_o,
	output mem_types_pkg::lane_mask_t           cdb_mask_o,
	output mem_types_pkg::warp_data_t           cdb_data_o
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	logic              s1_shared, conflict;
	lane_mask_t        s1_mask;
	lane_addr_arr_t    addr;
	warp_data_t        wdata, rdata;

	logic              mem_rd, mem_wr, acc_shared;
	lane_mask_t        acc_mask;

	logic              wb_valid, wb_load;
	logic [WARP_W-1:0] wb_warp;
	logic [SCB_W-1:0]  wb_scb;
	logic [REG_W-1:0]  wb_reg;
	lane_mask_t        wb_mask;

	mem_ctrl u_ctrl (
		.clk(clk), .rst(rst), .instr_valid_i(instr_valid_i),
		.mem_read_i(mem_read_i), .mem_write_i(mem_write_i), .shared_i(shared_i),
		.pam_i(pam_i), .warp_id_i(warp_id_i), .scb_id_i(scb_id_i),
		.reg_addr_i(reg_addr_i), .conflict_i(conflict),
		.shared_o(s1_shared), .mask_o(s1_mask),
		.mem_rd_o(mem_rd), .mem_wr_o(mem_wr), .acc_mask_o(acc_mask),
		.acc_shared_o(acc_shared),
		.wb_load_o(wb_load), .wb_valid_o(wb_valid), .wb_warp_o(wb_warp),
		.wb_scb_o(wb_scb), .wb_reg_o(wb_reg), .wb_mask_o(wb_mask),
		.neg_fb_valid_o(neg_fb_valid_o), .neg_fb_warp_o(neg_fb_warp_o),
		.neg_fb_scb_o(neg_fb_scb_o)
	);

	mem_addr_gen u_addr_gen (
		.clk(clk), .rst(rst), .instr_valid_i(instr_valid_i),
		.rs_data_i(rs_data_i), .rt_data_i(rt_data_i), .offset_i(offset_i),
		.shared_i(s1_shared), .mask_i(s1_mask),
		.addr_o(addr), .wdata_o(wdata), .conflict_o(conflict)
	);

	mem_bank_array u_bank_array (
		.clk(clk), .rst(rst), .mem_rd_i(mem_rd), .mem_wr_i(mem_wr),
		.shared_i(acc_shared), .mask_i(acc_mask), .addr_i(addr), .wdata_i(wdata),
		.fill_we_i(fill_we_i), .fill_line_i(fill_line_i), .fill_data_i(fill_data_i),
		.rdata_o(rdata)
	);

	mem_writeback u_writeback (
		.clk(clk), .rst(rst), .wb_valid_i(wb_valid), .wb_load_i(wb_load),
		.wb_warp_i(wb_warp), .wb_scb_i(wb_scb), .wb_reg_i(wb_reg),
		.wb_mask_i(wb_mask), .rdata_i(rdata),
		.pos_fb_valid_o(pos_fb_valid_o), .pos_fb_warp_o(pos_fb_warp_o),
		.pos_fb_scb_o(pos_fb_scb_o), .pos_fb_mask_o(pos_fb_mask_o),
		.cdb_we_o(cdb_we_o), .cdb_reg_o(cdb_reg_o), .cdb_mask_o(cdb_mask_o),
		.cdb_data_o(cdb_data_o)
	);

endmodule

// File: include/mem_tb_model.svh
`ifndef MEM_TB_MODEL_SVH
`define MEM_TB_MODEL_SVH

// ======================================================================
// Reference model of both memories and the pipeline
// ======================================================================

lane_word_t m_sh [NUM_BANKS][SH_ROWS];
lane_word_t m_gl [NUM_LINES][LINE_WORDS];

// Index k holds the instruction sampled k edges ago.
logic              h_valid [5];
logic              h_rd    [5];
logic              h_wr    [5];
logic              h_sh    [5];
logic              h_acc   [5];
logic              h_rej   [5];
lane_mask_t        h_mask  [5];
logic [WARP_W-1:0] h_warp  [5];
logic [SCB_W-1:0]  h_scb   [5];
logic [REG_W-1:0]  h_reg   [5];
warp_data_t        h_addr  [5];
warp_data_t        h_wdata [5];
warp_data_t        h_rdata [5];

task automatic model_reset();
	for (int k = 0; k < 5; k++)
	begin
		h_valid[k] = 1'b0;
		h_acc[k]   = 1'b0;
		h_rej[k]   = 1'b0;
	end
endtask

// Shared: same bank, other row. Global: other line.
function automatic logic model_conflict(logic sh, lane_mask_t m, warp_data_t a);
	logic c;
	c = 1'b0;
	for (int i = 0; i < NUM_LANES; i++)
		for (int j = i + 1; j < NUM_LANES; j++)
			if (m[i] && m[j])
			begin
				if (sh && a[i][2:0] == a[j][2:0] && a[i][7:3] != a[j][7:3])
					c = 1'b1;
				if (!sh && a[i][8:3] != a[j][8:3])
					c = 1'b1;
			end
	return c;
endfunction

// Called on every rising edge, before the new inputs take effect.
task automatic model_step();
	logic c;
	for (int k = 4; k > 0; k--)
	begin
		h_valid[k] = h_valid[k-1];
		h_rd[k]    = h_rd[k-1];
		h_wr[k]    = h_wr[k-1];
		h_sh[k]    = h_sh[k-1];
		h_acc[k]   = h_acc[k-1];
		h_rej[k]   = h_rej[k-1];
		h_mask[k]  = h_mask[k-1];
		h_warp[k]  = h_warp[k-1];
		h_scb[k]   = h_scb[k-1];
		h_reg[k]   = h_reg[k-1];
		h_addr[k]  = h_addr[k-1];
		h_wdata[k] = h_wdata[k-1];
		h_rdata[k] = h_rdata[k-1];
	end
	h_valid[0] = instr_valid_i;
	h_rd[0]    = mem_read_i;
	h_wr[0]    = mem_write_i;
	h_sh[0]    = shared_i;
	h_mask[0]  = pam_i;
	h_warp[0]  = warp_id_i;
	h_scb[0]   = scb_id_i;
	h_reg[0]   = reg_addr_i;
	h_wdata[0] = rt_data_i;
	h_rdata[0] = '0;
	for (int l = 0; l < NUM_LANES; l++)
		h_addr[0][l] = rs_data_i[l] + LANE_W'(offset_i);
	c = model_conflict(shared_i, pam_i, h_addr[0]);
	h_acc[0] = instr_valid_i && (mem_read_i || mem_write_i) && !c;
	h_rej[0] = instr_valid_i && (mem_read_i || mem_write_i) && c;
	// Loads see memory as it was before this edge.
	if (h_acc[3] && h_rd[3])
		for (int l = 0; l < NUM_LANES; l++)
			if (h_mask[3][l])
				h_rdata[3][l] = h_sh[3] ? m_sh[h_addr[3][l][2:0]][h_addr[3][l][7:3]]
					: m_gl[h_addr[3][l][8:3]][h_addr[3][l][2:0]];
	if (fill_we_i)
		for (int w = 0; w < LINE_WORDS; w++)
			m_gl[fill_line_i][w] = fill_data_i[w];
	// Store after fill, ascending lanes.
	if (h_acc[3] && h_wr[3] && !h_rd[3])
		for (int l = 0; l < NUM_LANES; l++)
			if (h_mask[3][l])
			begin
				if (h_sh[3])
					m_sh[h_addr[3][l][2:0]][h_addr[3][l][7:3]] = h_wdata[3][l];
				else
					m_gl[h_addr[3][l][8:3]][h_addr[3][l][2:0]] = h_wdata[3][l];
			end
endtask

`endif

// File: sim/mem_unit_tb.sv
`timescale 1ns/1ps

module mem_unit_tb;

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	localparam int TIMEOUT = 200;

	logic clk, rst, instr_valid_i, mem_read_i, mem_write_i, shared_i, fill_we_i;
	lane_mask_t pam_i, pos_fb_mask_o, cdb_mask_o;
	logic [WARP_W-1:0] warp_id_i, neg_fb_warp_o, pos_fb_warp_o;
	logic [SCB_W-1:0] scb_id_i, neg_fb_scb_o, pos_fb_scb_o;
	logic [REG_W-1:0] reg_addr_i, cdb_reg_o;
	warp_data_t rs_data_i, rt_data_i, fill_data_i, cdb_data_o;
	logic [OFFSET_W-1:0] offset_i;
	logic [FILL_ADDR_W-1:0] fill_line_i;
	logic neg_fb_valid_o, pos_fb_valid_o, cdb_we_o;
	logic checking;
	int n;

	mem_unit UUT (.*);

	`include "mem_tb_model.svh"

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		rst = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
	end

	// ======================================================================
	// Error reporting and compare tasks
	// ======================================================================

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped on error.");
	endtask

	task automatic value_error(string msg);
		$display("FAIL %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_strobe(string name, logic got, logic exp);
		if (got !== exp)
			value_error($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	task automatic check_neg(logic [WARP_W-1:0] warp, logic [SCB_W-1:0] scb);
		if (neg_fb_warp_o !== warp || neg_fb_scb_o !== scb)
			value_error($sformatf("neg fb warp %0d scb %0d, expected %0d %0d",
				neg_fb_warp_o, neg_fb_scb_o, warp, scb));
	endtask

	task automatic check_pos(logic [WARP_W-1:0] warp, logic [SCB_W-1:0] scb, lane_mask_t m);
		if (pos_fb_warp_o !== warp || pos_fb_scb_o !== scb || pos_fb_mask_o !== m)
			value_error($sformatf("pos fb %0d/%0d/%h, expected %0d/%0d/%h", pos_fb_warp_o,
				pos_fb_scb_o, pos_fb_mask_o, warp, scb, m));
	endtask

	task automatic check_cdb(logic [REG_W-1:0] rd, lane_mask_t m, warp_data_t d);
		if (cdb_reg_o !== rd || cdb_mask_o !== m || cdb_data_o !== d)
			value_error($sformatf("cdb r%0d %h %h, expected r%0d %h %h",
				cdb_reg_o, cdb_mask_o, cdb_data_o, rd, m, d));
	endtask

	always @(posedge clk)
		model_step();

	// Outputs are stable at the falling edge.
	always @(negedge clk)
	begin
		if (checking)
		begin
			check_strobe("neg_fb_valid_o", neg_fb_valid_o, h_valid[2] && h_rej[2]);
			if (h_valid[2] && h_rej[2])
				check_neg(h_warp[2], h_scb[2]);
			check_strobe("pos_fb_valid_o", pos_fb_valid_o, h_valid[4] && h_acc[4]);
			check_strobe("cdb_we_o", cdb_we_o, h_valid[4] && h_acc[4] && h_rd[4]);
			if (h_valid[4] && h_acc[4])
				check_pos(h_warp[4], h_scb[4], h_mask[4]);
			if (h_valid[4] && h_acc[4] && h_rd[4])
				check_cdb(h_reg[4], h_mask[4], h_rdata[4]);
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic drive_idle(logic fill, logic [FILL_ADDR_W-1:0] line, warp_data_t data);
		@(posedge clk);
		instr_valid_i <= 1'b0;
		fill_we_i     <= fill;
		fill_line_i   <= line;
		fill_data_i   <= data;
	endtask

	task automatic issue(logic rd, logic sh, lane_mask_t m, warp_data_t tgt);
		logic [OFFSET_W-1:0] off;
		warp_data_t rs;
		off = OFFSET_W'($urandom);
		for (int l = 0; l < NUM_LANES; l++)
			rs[l] = tgt[l] - LANE_W'(off);
		@(posedge clk);
		instr_valid_i <= 1'b1;
		mem_read_i    <= rd;
		mem_write_i   <= ~rd;
		shared_i      <= sh;
		pam_i         <= m;
		warp_id_i     <= WARP_W'($urandom);
		scb_id_i      <= SCB_W'($urandom);
		reg_addr_i    <= REG_W'($urandom);
		rs_data_i     <= rs;
		rt_data_i     <= {$urandom, $urandom, $urandom, $urandom,
			$urandom, $urandom, $urandom, $urandom};
		offset_i      <= off;
		fill_we_i     <= 1'b0;
	endtask

	// Kind 0 is coalesced, 1 splits lines, 2 is shared, 3 clashes banks and 4 repeats words.
	task automatic random_instr(int kind, logic rd);
		lane_mask_t m;
		warp_data_t tgt;
		logic [LINE_W-1:0] line;
		logic [SH_ROW_W-1:0] rows [NUM_BANKS];
		logic [2:0] x, bank;
		int a, b;
		m = NUM_LANES'($urandom);
		line = LINE_W'($urandom);
		x = 3'($urandom);
		for (int i = 0; i < NUM_BANKS; i++)
			rows[i] = SH_ROW_W'($urandom);
		a = $urandom_range(7, 0);
		b = (a + $urandom_range(7, 1)) % 8;
		if (kind == 1 || kind == 3)
			m = m | (8'd1 << a) | (8'd1 << b);
		for (int l = 0; l < NUM_LANES; l++)
		begin
			tgt[l] = $urandom;
			bank = 3'($urandom);
			if (m[l] && kind == 0)
				tgt[l][8:0] = {line, 3'(l) ^ x};
			else if (m[l] && (kind == 1 || kind == 4))
				tgt[l][8:0] = {line, 3'($urandom)};
			else if (m[l])
				tgt[l][7:0] = {rows[bank], bank};
		end
		if (kind == 1)
			tgt[b][8:3] = line + LINE_W'($urandom_range(63, 1));
		if (kind == 3)
			tgt[b][7:0] = {tgt[a][7:3] + SH_ROW_W'($urandom_range(31, 1)), tgt[a][2:0]};
		issue(rd, kind >= 2 && kind <= 3, m, tgt);
	endtask

	task automatic run_phase(int count, int kind_lo, int kind_hi, int load_pct, int gap_pct);
		for (int i = 0; i < count; i++)
		begin
			if ($urandom_range(99, 0) < gap_pct)
				drive_idle($urandom_range(1, 0) == 1, FILL_ADDR_W'($urandom),
					{$urandom, $urandom, $urandom, $urandom,
					$urandom, $urandom, $urandom, $urandom});
			else
				random_instr($urandom_range(kind_hi, kind_lo),
					$urandom_range(99, 0) < load_pct);
		end
	endtask

	initial
	begin
		warp_data_t tgt;
		void'($urandom(32'h1d01_5fcc));
		model_reset();
		checking = 1'b0;
		{instr_valid_i, mem_read_i, mem_write_i, shared_i, fill_we_i} = '0;
		{pam_i, warp_id_i, scb_id_i, reg_addr_i, offset_i, fill_line_i} = '0;
		{rs_data_i, rt_data_i, fill_data_i} = '0;
		n = 0;
		while (rst !== 1'b1)
		begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
			begin
				$display("Timeout while waiting for reset release.");
				stop_run();
			end
		end
		checking = 1'b1;
		// Preload global lines through the fill port and shared rows by stores.
		for (int ln = 0; ln < NUM_LINES; ln++)
			drive_idle(1'b1, FILL_ADDR_W'(ln), {$urandom, $urandom, $urandom, $urandom,
				$urandom, $urandom, $urandom, $urandom});
		for (int r = 0; r < SH_ROWS; r++)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				tgt[l] = $urandom;
				tgt[l][7:0] = 8'(r * 8 + l);
			end
			issue(1'b0, 1'b1, 8'hff, tgt);
		end
		run_phase(60, 0, 0, 100, 20);
		run_phase(80, 2, 4, 50, 10);
		run_phase(60, 2, 3, 50, 10);
		run_phase(60, 0, 1, 50, 10);
		run_phase(600, 0, 4, 50, 25);
		drive_idle(1'b0, '0, '0);
		n = 0;
		while (h_valid[0] || h_valid[1] || h_valid[2] || h_valid[3] || h_valid[4])
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
			begin
				$display("Timeout while draining the pipeline.");
				stop_run();
			end
		end
		@(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
rtl/mem_cfg_pkg.sv
rtl/mem_types_pkg.sv
rtl/mem_ctrl.sv
rtl/mem_addr_gen.sv
rtl/mem_bank_array.sv
rtl/mem_writeback.sv
rtl/mem_unit.sv
sim/mem_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= mem_unit_tb
RTL_TOP   ?= mem_unit
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= All tests passed!

RTL_FILES := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST) | grep -v '^+') include/mem_tb_model.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
